// ==== list.f ====
+incdir+common
common/mul_pkg.sv
common/csa_bus_if.sv
array_mul/pp_gen_stage.sv
array_mul/csa_row_stage.sv
array_mul/cpa_stage.sv
verilog/array_mul_top.sv
verif/array_mul_assertions.sv
verif/array_mul_tb.sv

// ==== verif/array_mul_golden.txt ====
# mode a b expected_p idle_cycles   (mode 0 is one 16x16 product, 1 is two 8x8 lanes)
# a, b, expected_p in hex, idle_cycles in decimal before the strobe; '@ name' opens a test group
@ full_mode
0 0000 0000 00000000 1
0 0001 0001 00000001 1
0 FFFF FFFF FFFE0001 1
0 FFFF 0001 0000FFFF 1
0 0100 0100 00010000 1
0 8000 8000 40000000 1
0 1234 0010 00012340 1
0 00FF 00FF 0000FE01 1
0 1234 5678 06260060 1
@ split_mode
1 FFFF FFFF FE01FE01 1
1 0102 0304 00030008 1
1 FF00 FF00 FE010000 1
1 00FF 00FF 0000FE01 1
1 1234 5678 060C1860 1
1 FF01 01FF 00FF00FF 1
1 8080 8080 40004000 1
@ streaming
0 ABCD 0002 0001579A 2
1 ABCD 0002 0000019A 0
0 0003 0005 0000000F 0
1 0305 0709 0015002D 0
0 1000 0010 00010000 0
1 1010 1010 01000100 0
@ gaps
0 0007 0009 0000003F 3
1 0203 0405 0008000F 5
0 FFFF 0002 0001FFFE 2
1 FFFF 0101 00FF00FF 4

// ==== verif/array_mul_tb.sv ====
`timescale 1ns/1ps

module array_mul_tb import mul_pkg::*; ();

   localparam int    RESET_CYCLES = 8;
   localparam string GOLDEN_FILE  = "verif/array_mul_golden.txt";

   logic     clk;
   logic     arst_n;
   logic     in_valid;
   logic     para_mode;
   operand_t a;
   operand_t b;
   logic     out_valid;
   product_t p;

   // Vectors from the golden file
   logic     vec_mode[$];
   operand_t vec_a[$];
   operand_t vec_b[$];
   product_t vec_exp[$];
   int       vec_gap[$];
   int       vec_grp[$];
   string    grp_name[$];
   int       grp_total[$];
   int       grp_seen[$];
   int       grp_err[$];

   // Transactions in flight
   product_t pend_exp[$];
   int       pend_cycle[$];
   int       pend_grp[$];
   string    pend_name[$];

   int       errors = 0;
   int       checked = 0;
   int       cycle_cnt = 0;
   int       gap_sum = 0;
   bit       loaded = 0;

   array_mul_top array_mul_top_i (
      .clk       (clk),
      .arst_n    (arst_n),
      .in_valid  (in_valid),
      .para_mode (para_mode),
      .a         (a),
      .b         (b),
      .out_valid (out_valid),
      .p         (p)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

   function automatic product_t expected_product(input logic mode, input operand_t x,
                                                 input operand_t y);
      logic [15:0] hi;
      logic [15:0] lo;
      if (mode) begin
         hi = x[15:8] * y[15:8];   // 16-bit lane results
         lo = x[7:0] * y[7:0];
         return {hi, lo};
      end
      return x * y;
   endfunction

   function automatic string trim_line(input string s);
      int n;
      n = s.len();
      while (n > 0 && (s[n-1] == "\n" || s[n-1] == "\r" || s[n-1] == " ")) begin
         n--;
      end
      return s.substr(0, n - 1);
   endfunction

   task automatic check_value(input string test, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected) begin
         $display("ERR %s expected 0x%h actual 0x%h", test, expected, actual);
         errors++;
      end
   endtask

   task automatic load_golden();
      int          fd;
      int          n;
      string       line;
      logic [31:0] m;
      logic [31:0] va;
      logic [31:0] vb;
      logic [31:0] ve;
      int          vg;
      fd = $fopen(GOLDEN_FILE, "r");
      if (fd == 0) begin
         $display("cannot open %s", GOLDEN_FILE);
         errors++;
         return;
      end
      while ($fgets(line, fd)) begin
         line = trim_line(line);
         if (line.len() == 0 || line[0] == "#") continue;
         if (line[0] == "@") begin
            grp_name.push_back(line.substr(2, line.len() - 1));
            grp_total.push_back(0);
            grp_seen.push_back(0);
            grp_err.push_back(0);
            continue;
         end
         n = $sscanf(line, "%h %h %h %h %d", m, va, vb, ve, vg);
         if (n != 5 || grp_name.size() == 0) begin
            $display("malformed golden line: %s", line);
            errors++;
            continue;
         end
         // Golden entry must agree with the multiplier rules
         check_value("golden entry", expected_product(m[0], va, vb), ve);
         vec_mode.push_back(m[0]);
         vec_a.push_back(va);
         vec_b.push_back(vb);
         vec_exp.push_back(ve);
         vec_gap.push_back(vg);
         vec_grp.push_back(grp_name.size() - 1);
         grp_total[grp_name.size()-1] = grp_total[grp_name.size()-1] + 1;
         gap_sum += vg;
      end
      $fclose(fd);
   endtask

   // Outputs are registered, so the falling edge sees them settled
   always @(negedge clk) begin
      string    name;
      product_t exp_p;
      int       exp_cycle;
      int       g;
      int       err_before;
      if (arst_n === 1'b0) begin
         if (out_valid !== 1'b0) begin
            $display("out_valid is not low while reset is asserted");
            errors++;
         end
      end else if (out_valid === 1'b1) begin
         if (pend_exp.size() == 0) begin
            $display("out_valid high at cycle %0d with no transaction in flight", cycle_cnt);
            errors++;
         end else begin
            name       = pend_name.pop_front();
            exp_p      = pend_exp.pop_front();
            exp_cycle  = pend_cycle.pop_front();
            g          = pend_grp.pop_front();
            err_before = errors;
            check_value(name, exp_p, p);
            check_value({name, " output cycle"}, exp_cycle, cycle_cnt);
            checked++;
            grp_err[g]  = grp_err[g] + errors - err_before;
            grp_seen[g] = grp_seen[g] + 1;
            if (grp_seen[g] == grp_total[g]) begin
               $display("test %s: %0d vectors, %0d errors", grp_name[g], grp_total[g],
                        grp_err[g]);
            end
         end
      end else if (out_valid !== 1'b0) begin
         $display("out_valid is unknown at cycle %0d", cycle_cnt);
         errors++;
      end
   end

   initial begin
      int limit;
      wait (loaded);
      limit = vec_a.size() + gap_sum + RESET_CYCLES + 20;
      repeat (limit) @(posedge clk);
      $display("watchdog expired after %0d clock periods, results still missing", limit);
      $display("TESTBENCH FAILED");
      $finish;
   end

   initial begin
      int drain;
      arst_n    = 1'b1;
      in_valid  = 1'b0;
      para_mode = 1'b0;
      a         = '0;
      b         = '0;
      load_golden();
      loaded = 1'b1;
      #1 arst_n = 1'b0;
      repeat (RESET_CYCLES) @(negedge clk);
      arst_n = 1'b1;
      repeat (3) @(negedge clk);   // Idle after reset, monitor flags any output
      for (int i = 0; i < vec_a.size(); i++) begin
         in_valid = 1'b0;
         repeat (vec_gap[i]) @(negedge clk);
         in_valid  = 1'b1;
         para_mode = vec_mode[i];
         a         = vec_a[i];
         b         = vec_b[i];
         pend_exp.push_back(vec_exp[i]);
         pend_cycle.push_back(cycle_cnt + 4);
         pend_grp.push_back(vec_grp[i]);
         pend_name.push_back($sformatf("%s #%0d", grp_name[vec_grp[i]], i));
         @(negedge clk);
      end
      in_valid = 1'b0;
      drain = 0;
      while (pend_exp.size() != 0 && drain < 8) begin
         @(negedge clk);
         drain++;
      end
      if (pend_exp.size() != 0) begin
         $display("%0d transactions never produced a result", pend_exp.size());
         errors++;
      end
      repeat (2) @(negedge clk);
      errors += array_mul_top_i.array_mul_assertions_i.fail_cnt;
      $display("summary: %0d tests, %0d vectors checked, %0d errors",
               grp_name.size(), checked, errors);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

// ==== verif/array_mul_assertions.sv ====
`timescale 1ns/1ps
`include "mul_consts.svh"

module array_mul_assertions import mul_pkg::*; (
   input logic     clk,
   input logic     arst_n,
   input logic     in_valid,
   input logic     para_mode,
   input logic     out_valid,
   input product_t p
);

   // Largest product of two lane values
   localparam logic [`MUL_OP_W-1:0] LANE_MAX =
      ((1 << `MUL_LANE_W) - 1) * ((1 << `MUL_LANE_W) - 1);

   int fail_cnt = 0;   // Failed assertion attempts so far

   a_reset_quiet: assert property (@(posedge clk) !arst_n |-> !out_valid)
      else begin
         $error("out_valid high while reset is asserted");
         fail_cnt++;
      end

   a_latency: assert property (@(posedge clk) disable iff (!arst_n)
      in_valid |-> ##4 out_valid)
      else begin
         $error("no out_valid four cycles after in_valid");
         fail_cnt++;
      end

   a_no_orphan: assert property (@(posedge clk) disable iff (!arst_n)
      out_valid |-> $past(in_valid, 4))
      else begin
         $error("out_valid without a matching in_valid");
         fail_cnt++;
      end

   // Mode of the transaction now leaving the pipe
   a_split_upper: assert property (@(posedge clk) disable iff (!arst_n)
      (out_valid && $past(para_mode, 4)) |-> (p[2*`MUL_OP_W-1:`MUL_OP_W] <= LANE_MAX))
      else begin
         $error("split mode upper lane exceeds the largest 8x8 product");
         fail_cnt++;
      end

   a_split_lower: assert property (@(posedge clk) disable iff (!arst_n)
      (out_valid && $past(para_mode, 4)) |-> (p[`MUL_OP_W-1:0] <= LANE_MAX))
      else begin
         $error("split mode lower lane exceeds the largest 8x8 product");
         fail_cnt++;
      end

endmodule

bind array_mul_top array_mul_assertions array_mul_assertions_i (
   .clk       (clk),
   .arst_n    (arst_n),
   .in_valid  (in_valid),
   .para_mode (para_mode),
   .out_valid (out_valid),
   .p         (p)
);

// ==== verilog/array_mul_top.sv ====
`timescale 1ns/1ps
`include "mul_consts.svh"

module array_mul_top import mul_pkg::*; (
   input  logic     clk,
   input  logic     arst_n,
   input  logic     in_valid,
   input  logic     para_mode,
   input  operand_t a,
   input  operand_t b,
   output logic     out_valid,
   output product_t p
);

   csa_bus_if pp_bus ();    // Matrix, nothing reduced yet
   csa_bus_if mid_bus ();   // Low block of rows folded in
   csa_bus_if red_bus ();   // All rows folded in

   // Stage 1
   pp_gen_stage pp_gen_stage_i (
      .clk       (clk),
      .arst_n    (arst_n),
      .in_valid  (in_valid),
      .para_mode (para_mode),
      .a         (a),
      .b         (b),
      .out_bus   (pp_bus.src)
   );

   // Stage 2, rows 0 to 7
   csa_row_stage #(
      .FIRST_ROW (0),
      .NUM_ROWS  (`MUL_ROWS_PER_STAGE)
   ) csa_row_stage_0_i (
      .clk     (clk),
      .arst_n  (arst_n),
      .in_bus  (pp_bus.dst),
      .out_bus (mid_bus.src)
   );

   // Stage 3, rows 8 to 15
   csa_row_stage #(
      .FIRST_ROW (`MUL_ROWS_PER_STAGE),
      .NUM_ROWS  (`MUL_ROWS_PER_STAGE)
   ) csa_row_stage_1_i (
      .clk     (clk),
      .arst_n  (arst_n),
      .in_bus  (mid_bus.dst),
      .out_bus (red_bus.src)
   );

   // Stage 4
   cpa_stage cpa_stage_i (
      .clk       (clk),
      .arst_n    (arst_n),
      .in_bus    (red_bus.dst),
      .out_valid (out_valid),
      .p         (p)
   );

endmodule

// ==== array_mul/cpa_stage.sv ====
`timescale 1ns/1ps
`include "mul_consts.svh"

module cpa_stage import mul_pkg::*; (
   input  logic     clk,
   input  logic     arst_n,
   csa_bus_if.dst   in_bus,
   output logic     out_valid,
   output product_t p
);

   localparam int PW = 2 * `MUL_OP_W;

   product_t c_shift;
   product_t p_next;

   assign c_shift = {in_bus.carry[PW-2:0], 1'b0};

   // Ripple row, last stage of the array
   always_comb begin
      logic cy;
      cy = 1'b0;
      for (int i = 0; i < PW; i++) begin
         p_next[i] = in_bus.sum[i] ^ c_shift[i] ^ cy;
         cy        = (in_bus.sum[i] & c_shift[i])
                   | (in_bus.sum[i] & cy)
                   | (c_shift[i] & cy);
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         out_valid <= 1'b0;
      end else begin
         out_valid <= in_bus.valid;
      end
   end

   always_ff @(posedge clk) begin
      if (in_bus.valid) begin
         p <= p_next;   // Carry out of the top bit is always zero
      end
   end

endmodule

// ==== array_mul/csa_row_stage.sv ====
`timescale 1ns/1ps
`include "mul_consts.svh"

module csa_row_stage import mul_pkg::*; #(
   parameter int FIRST_ROW = 0,
   parameter int NUM_ROWS  = `MUL_ROWS_PER_STAGE
) (
   input  logic   clk,
   input  logic   arst_n,
   csa_bus_if.dst in_bus,
   csa_bus_if.src out_bus
);

   localparam int PW = 2 * `MUL_OP_W;

   product_t   sum_chain   [NUM_ROWS+1];
   product_t   carry_chain [NUM_ROWS+1];
   pp_matrix_t pp_left;
   logic       valid_q;
   logic       mode_q;
   product_t   sum_q;
   product_t   carry_q;
   pp_matrix_t pp_q;

   assign sum_chain[0]   = in_bus.sum;
   assign carry_chain[0] = in_bus.carry;

   // One carry-save row per partial product
   for (genvar k = 0; k < NUM_ROWS; k++) begin : g_row
      product_t addend;
      product_t c_in;
      product_t s_in;

      assign addend = product_t'(in_bus.pp[FIRST_ROW+k]) << (FIRST_ROW + k);
      assign c_in   = {carry_chain[k][PW-2:0], 1'b0};   // Carries weigh one bit up
      assign s_in   = sum_chain[k];

      // Full adder on every bit position
      assign sum_chain[k+1]   = s_in ^ c_in ^ addend;
      assign carry_chain[k+1] = (s_in & c_in)
                              | (s_in & addend)
                              | (c_in & addend);
   end

   // Rows of this block are spent
   always_comb begin
      pp_left = in_bus.pp;
      for (int r = FIRST_ROW; r < FIRST_ROW + NUM_ROWS; r++) begin
         pp_left[r] = '0;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= in_bus.valid;
      end
   end

   always_ff @(posedge clk) begin
      if (in_bus.valid) begin
         mode_q  <= in_bus.para_mode;
         sum_q   <= sum_chain[NUM_ROWS];
         carry_q <= carry_chain[NUM_ROWS];
         pp_q    <= pp_left;
      end
   end

   assign out_bus.valid     = valid_q;
   assign out_bus.para_mode = mode_q;
   assign out_bus.pp        = pp_q;
   assign out_bus.sum       = sum_q;
   assign out_bus.carry     = carry_q;

endmodule

// ==== array_mul/pp_gen_stage.sv ====
`timescale 1ns/1ps
`include "mul_consts.svh"

module pp_gen_stage import mul_pkg::*; (
   input  logic     clk,
   input  logic     arst_n,
   input  logic     in_valid,
   input  logic     para_mode,
   input  operand_t a,
   input  operand_t b,
   csa_bus_if.src   out_bus
);

   lane_t      a_lo;
   lane_t      a_hi;
   operand_t   a_low_rows;    // Multiplicand seen by rows of the low lane of b
   operand_t   a_high_rows;
   pp_matrix_t pp_next;
   logic       valid_q;
   logic       mode_q;
   pp_matrix_t pp_q;

   assign a_lo = a[`MUL_LANE_W-1:0];
   assign a_hi = a[`MUL_OP_W-1:`MUL_LANE_W];

   // Split mode keeps each lane product in its own half of p
   assign a_low_rows  = para_mode ? operand_t'(a_lo) : a;
   assign a_high_rows = para_mode ? {a_hi, {`MUL_LANE_W{1'b0}}} : a;

   // AND matrix
   always_comb begin
      for (int r = 0; r < `MUL_ROWS; r++) begin
         if (r < `MUL_LANE_W) begin
            pp_next[r] = a_low_rows & {`MUL_OP_W{b[r]}};
         end else begin
            pp_next[r] = a_high_rows & {`MUL_OP_W{b[r]}};
         end
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= in_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (in_valid) begin
         mode_q <= para_mode;
         pp_q   <= pp_next;
      end
   end

   assign out_bus.valid     = valid_q;
   assign out_bus.para_mode = mode_q;
   assign out_bus.pp        = pp_q;
   assign out_bus.sum       = '0;   // Nothing accumulated yet
   assign out_bus.carry     = '0;

endmodule

// ==== common/csa_bus_if.sv ====
`timescale 1ns/1ps

// One multiplication in flight between two pipeline stages
interface csa_bus_if;

   logic                valid;
   logic                para_mode;   // Debug only, masking already applied
   mul_pkg::pp_matrix_t pp;          // Rows still to be folded in
   mul_pkg::product_t   sum;
   mul_pkg::product_t   carry;       // Unshifted, bit i weighs 2**(i+1)

   modport src (
      output valid,
      output para_mode,
      output pp,
      output sum,
      output carry
   );

   modport dst (
      input valid,
      input para_mode,
      input pp,
      input sum,
      input carry
   );

endinterface

// ==== common/mul_pkg.sv ====
`include "mul_consts.svh"

package mul_pkg;

   // One operand word
   typedef logic [`MUL_OP_W-1:0] operand_t;

   // Half an operand, split mode
   typedef logic [`MUL_LANE_W-1:0] lane_t;

   // Full-width product, also used for the sum and carry vectors
   typedef logic [2*`MUL_OP_W-1:0] product_t;

   // Masked partial product, not yet shifted into place
   typedef logic [`MUL_OP_W-1:0] pp_row_t;

   // Row r carries a & b[r]
   typedef pp_row_t [`MUL_ROWS-1:0] pp_matrix_t;

endpackage

// ==== common/mul_consts.svh ====
`ifndef MUL_CONSTS_SVH
`define MUL_CONSTS_SVH

// Operand width of the array multiplier
`define MUL_OP_W 16

// One lane in split mode, two lanes per operand
`define MUL_LANE_W 8

// One partial-product row per bit of b
`define MUL_ROWS `MUL_OP_W

// Rows folded in by each carry-save stage
`define MUL_ROWS_PER_STAGE 8

`endif
